/* Makefile */
# Verilator build and run of the vector lane testbench

VERILATOR ?= verilator
TOP       ?= tb_lane
FILELIST  ?= lane.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_STR  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_lane.sv */
// Vector lane testbench
// Random loads, ALU ops and stores checked against a register-file model

module tb_lane
  import lane_pkg::*;
  import vinsn_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned Timeout   = 500;
  localparam int unsigned NrLoads   = 24;
  localparam int unsigned NrAluOps  = 40;
  localparam int unsigned NrSameReg = 12;
  localparam int unsigned NrStores  = 24;

  logic      clk_i, rst_ni;
  logic      vinsn_valid_i, vinsn_ready_o, vinsn_done_o;
  vop_e      vinsn_op_i;
  vreg_t     vinsn_vd_i, vinsn_vs1_i, vinsn_vs2_i;
  vl_t       vinsn_vl_i;
  vid_t      vinsn_id_i, vinsn_done_id_o;
  logic      ldu_req_i, ldu_gnt_o;
  vreg_t     ldu_vreg_i;
  elem_idx_t ldu_elem_i;
  elen_t     ldu_wdata_i;
  strb_t     ldu_be_i;
  elen_t     stu_operand_o;
  logic      stu_operand_valid_o, stu_operand_ready_i;

  // Expected register contents
  elen_t       model [NrVRegs][ElemsPerVreg];
  elen_t       st_data [$];
  int unsigned errors, checks, handshake_errors;
  int unsigned nr_accepted, nr_done, base;
  vid_t        next_id;

  lane uut (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (rst_ni && vinsn_done_o) begin
      nr_done++;
    end
  end

  //////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////

  function automatic logic check_value(string name, elen_t got, elen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t ns %s: got %h, expected %h", $time, name, got, exp);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic report_handshake_error(string msg);
    errors++;
    handshake_errors++;
    $display("ERROR %0t ns: %s", $time, msg);
  endtask

  task automatic abort_on_timeout(string what);
    $display("ERROR %0t ns: timed out waiting for %s", $time, what);
    $display("Result: FAILED");
    $finish;
  endtask

  task automatic finish_test(int num, string name, int unsigned nerr);
    $display("Test %0d %s finished with %0d errors", num, name, nerr);
  endtask

  // vd = vs2 op vs1
  function automatic elen_t alu_ref(vop_e op, elen_t vs1, elen_t vs2);
    case (op)
      VADD:    return vs2 + vs1;
      VSUB:    return vs2 - vs1;
      VAND:    return vs2 & vs1;
      VOR:     return vs2 | vs1;
      VXOR:    return vs2 ^ vs1;
      default: return '0;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  task automatic load_elem(vreg_t vreg, elem_idx_t elem, elen_t data, strb_t be);
    int unsigned cycles;
    logic        granted;
    ldu_req_i   = 1'b1;
    ldu_vreg_i  = vreg;
    ldu_elem_i  = elem;
    ldu_wdata_i = data;
    ldu_be_i    = be;
    granted     = 1'b0;
    cycles      = 0;
    while (!granted && cycles < Timeout) begin
      @(posedge clk_i);
      granted = ldu_gnt_o;
      cycles++;
    end
    #1;
    ldu_req_i = 1'b0;
    if (!granted) begin
      abort_on_timeout("load grant");
    end
    for (int i = 0; i < ElenW / 8; i++) begin
      if (be[i]) begin
        model[vreg][elem][8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  // Issues one instruction and collects store data until its done pulse
  task automatic run_insn(vop_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, vl_t vl,
                          logic backpressure);
    int unsigned cycles;
    logic        accepted, done;
    vid_t        id;
    id = next_id;
    next_id++;
    st_data.delete();
    vinsn_valid_i = 1'b1;
    vinsn_op_i    = op;
    vinsn_vd_i    = vd;
    vinsn_vs1_i   = vs1;
    vinsn_vs2_i   = vs2;
    vinsn_vl_i    = vl;
    vinsn_id_i    = id;
    accepted      = 1'b0;
    cycles        = 0;
    while (!accepted && cycles < Timeout) begin
      @(posedge clk_i);
      accepted = vinsn_ready_o;
      cycles++;
    end
    #1;
    vinsn_valid_i = 1'b0;
    if (!accepted) begin
      abort_on_timeout("instruction accept");
    end
    nr_accepted++;
    // Ready one cycle in three so queue B fills up
    stu_operand_ready_i = backpressure ? ($urandom_range(2) == 0) : 1'b1;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < Timeout) begin
      @(posedge clk_i);
      if (stu_operand_valid_o && stu_operand_ready_i) begin
        st_data.push_back(stu_operand_o);
      end
      if (vinsn_ready_o) begin
        report_handshake_error("vinsn_ready_o high between accept and done");
      end
      if (vinsn_done_o) begin
        done = 1'b1;
        if (!check_value("vinsn_done_id_o", elen_t'(vinsn_done_id_o), elen_t'(id))) begin
          handshake_errors++;
        end
      end
      cycles++;
      #1;
      stu_operand_ready_i = backpressure ? ($urandom_range(2) == 0) : 1'b1;
    end
    if (!done) begin
      abort_on_timeout("done pulse");
    end
    // Lane is idle again one cycle later
    @(posedge clk_i);
    if (!vinsn_ready_o) begin
      report_handshake_error("vinsn_ready_o low after done");
    end
    if (vinsn_done_o) begin
      report_handshake_error("second done pulse for one instruction");
    end
    #1;
    stu_operand_ready_i = 1'b1;
  endtask

  task automatic check_stream(vreg_t vreg, vl_t vl);
    void'(check_value("stu_operand_o count", elen_t'(st_data.size()), elen_t'(vl)));
    for (int i = 0; i < int'(vl) && i < st_data.size(); i++) begin
      void'(check_value($sformatf("stu_operand_o[%0d]", i), st_data[i], model[vreg][i]));
    end
  endtask

  task automatic alu_then_store(vop_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, vl_t vl);
    run_insn(op, vd, vs1, vs2, vl, 1'b0);
    for (int i = 0; i < int'(vl); i++) begin
      model[vd][i] = alu_ref(op, model[vs1][i], model[vs2][i]);
    end
    // Full-length store also covers the untouched tail
    run_insn(VSTORE, '0, '0, vd, vl_t'(ElemsPerVreg), 1'b0);
    check_stream(vd, vl_t'(ElemsPerVreg));
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h62c7_9ec4));
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    vinsn_valid_i       = 1'b0;
    vinsn_op_i          = VADD;
    vinsn_vd_i          = '0;
    vinsn_vs1_i         = '0;
    vinsn_vs2_i         = '0;
    vinsn_vl_i          = '0;
    vinsn_id_i          = '0;
    ldu_req_i           = 1'b0;
    ldu_vreg_i          = '0;
    ldu_elem_i          = '0;
    ldu_wdata_i         = '0;
    ldu_be_i            = '0;
    stu_operand_ready_i = 1'b1;
    errors              = 0;
    checks              = 0;
    handshake_errors    = 0;
    nr_accepted         = 0;
    nr_done             = 0;
    next_id             = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    base = errors;
    void'(check_value("vinsn_ready_o", elen_t'(vinsn_ready_o), 32'd1));
    void'(check_value("vinsn_done_o", elen_t'(vinsn_done_o), 32'd0));
    void'(check_value("ldu_gnt_o", elen_t'(ldu_gnt_o), 32'd0));
    void'(check_value("stu_operand_valid_o", elen_t'(stu_operand_valid_o), 32'd0));
    finish_test(1, "reset values", errors - base);

    // Known contents everywhere before any read
    for (int v = 0; v < NrVRegs; v++) begin
      for (int e = 0; e < ElemsPerVreg; e++) begin
        load_elem(vreg_t'(v), elem_idx_t'(e), elen_t'($urandom()), '1);
      end
    end

    base = errors;
    for (int n = 0; n < NrLoads; n++) begin
      vreg_t v;
      v = vreg_t'($urandom_range(NrVRegs - 1));
      load_elem(v, elem_idx_t'($urandom_range(ElemsPerVreg - 1)), elen_t'($urandom()),
                strb_t'($urandom_range(15)));
      run_insn(VSTORE, '0, '0, v, vl_t'(ElemsPerVreg), 1'b0);
      check_stream(v, vl_t'(ElemsPerVreg));
    end
    finish_test(2, "byte-enable loads", errors - base);

    base = errors;
    for (int n = 0; n < NrAluOps; n++) begin
      alu_then_store(vop_e'(3'($urandom_range(4))), vreg_t'($urandom_range(NrVRegs - 1)),
                     vreg_t'($urandom_range(NrVRegs - 1)),
                     vreg_t'($urandom_range(NrVRegs - 1)),
                     vl_t'($urandom_range(ElemsPerVreg)));
    end
    finish_test(3, "random ALU ops", errors - base);

    base = errors;
    for (int n = 0; n < NrSameReg; n++) begin
      vreg_t r;
      r = vreg_t'($urandom_range(NrVRegs - 1));
      alu_then_store(vop_e'(3'($urandom_range(4))), r, r, r,
                     vl_t'($urandom_range(ElemsPerVreg, 1)));
    end
    finish_test(4, "same-register ops", errors - base);

    base = errors;
    for (int n = 0; n < NrStores; n++) begin
      vreg_t v;
      vl_t   vl;
      v  = vreg_t'($urandom_range(NrVRegs - 1));
      vl = vl_t'($urandom_range(ElemsPerVreg));
      run_insn(VSTORE, '0, '0, v, vl, 1'b1);
      check_stream(v, vl);
    end
    finish_test(5, "stores under back-pressure", errors - base);

    repeat (2) @(posedge clk_i);
    #1;
    base = errors;
    void'(check_value("vinsn_done_o pulse count", elen_t'(nr_done), elen_t'(nr_accepted)));
    finish_test(6, "done pulses and IDs", errors - base + handshake_errors);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* lane.f */
rtl/lane_pkg.sv
rtl/vinsn_pkg.sv
rtl/lane_sequencer.sv
rtl/operand_requester.sv
rtl/vector_regfile.sv
rtl/operand_queue.sv
rtl/lane_exec_unit.sv
rtl/lane.sv
dv/tb_lane.sv

/* rtl/lane.sv */
// Vector lane top level
// Sequencer, operand requester, banked register file, operand queues
// and execution unit

module lane
  import lane_pkg::*;
  import vinsn_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // Instruction interface
  input  logic      vinsn_valid_i,
  input  vop_e      vinsn_op_i,
  input  vreg_t     vinsn_vd_i,
  input  vreg_t     vinsn_vs1_i,
  input  vreg_t     vinsn_vs2_i,
  input  vl_t       vinsn_vl_i,
  input  vid_t      vinsn_id_i,
  output logic      vinsn_ready_o,
  output logic      vinsn_done_o,
  output vid_t      vinsn_done_id_o,
  // Load port
  input  logic      ldu_req_i,
  input  vreg_t     ldu_vreg_i,
  input  elem_idx_t ldu_elem_i,
  input  elen_t     ldu_wdata_i,
  input  strb_t     ldu_be_i,
  output logic      ldu_gnt_o,
  // Store port
  output elen_t     stu_operand_o,
  output logic      stu_operand_valid_o,
  input  logic      stu_operand_ready_i
);

  // Sequencer to requester
  logic      rd_req_valid, rd_req_ready;
  vreg_t     rd_req_vreg;
  elem_idx_t rd_req_elem;
  opq_sel_e  rd_req_opq;
  // Sequencer and execution unit
  logic      exec_start, exec_done;
  vop_e      exec_op;
  vreg_t     exec_vd;
  vl_t       exec_vl;
  // Result write-back
  logic      res_req, res_gnt;
  vreg_t     res_vreg;
  elem_idx_t res_elem;
  elen_t     res_wdata;
  // Register file banks
  logic       [NrBanks-1:0] vrf_req, vrf_wen;
  bank_addr_t [NrBanks-1:0] vrf_addr;
  elen_t      [NrBanks-1:0] vrf_wdata;
  strb_t      [NrBanks-1:0] vrf_be;
  opq_sel_e   [NrBanks-1:0] vrf_tgt;
  // Operand queues
  elen_t [NrOpQueues-1:0] vrf_operand;
  logic  [NrOpQueues-1:0] vrf_operand_valid;
  logic  [NrOpQueues-1:0] opq_space_ok;
  elen_t                  opa_data, opb_data;
  logic                   opa_valid, opa_ready, opb_valid, opb_ready;

  lane_sequencer u_sequencer (
    .clk_i, .rst_ni,
    .vinsn_valid_i, .vinsn_op_i, .vinsn_vd_i, .vinsn_vs1_i, .vinsn_vs2_i,
    .vinsn_vl_i, .vinsn_id_i, .vinsn_ready_o, .vinsn_done_o, .vinsn_done_id_o,
    .rd_req_valid_o (rd_req_valid),
    .rd_req_vreg_o  (rd_req_vreg),
    .rd_req_elem_o  (rd_req_elem),
    .rd_req_opq_o   (rd_req_opq),
    .rd_req_ready_i (rd_req_ready),
    .exec_start_o   (exec_start),
    .exec_op_o      (exec_op),
    .exec_vd_o      (exec_vd),
    .exec_vl_o      (exec_vl),
    .exec_done_i    (exec_done)
  );

  operand_requester u_requester (
    .clk_i, .rst_ni,
    .rd_req_valid_i (rd_req_valid),
    .rd_req_vreg_i  (rd_req_vreg),
    .rd_req_elem_i  (rd_req_elem),
    .rd_req_opq_i   (rd_req_opq),
    .rd_req_ready_o (rd_req_ready),
    .opq_space_ok_i (opq_space_ok),
    .res_req_i      (res_req),
    .res_vreg_i     (res_vreg),
    .res_elem_i     (res_elem),
    .res_wdata_i    (res_wdata),
    .res_gnt_o      (res_gnt),
    .ldu_req_i, .ldu_vreg_i, .ldu_elem_i, .ldu_wdata_i, .ldu_be_i, .ldu_gnt_o,
    .vrf_req_o      (vrf_req),
    .vrf_wen_o      (vrf_wen),
    .vrf_addr_o     (vrf_addr),
    .vrf_wdata_o    (vrf_wdata),
    .vrf_be_o       (vrf_be),
    .vrf_tgt_o      (vrf_tgt)
  );

  vector_regfile u_vrf (
    .clk_i, .rst_ni,
    .req_i           (vrf_req),
    .wen_i           (vrf_wen),
    .addr_i          (vrf_addr),
    .wdata_i         (vrf_wdata),
    .be_i            (vrf_be),
    .tgt_i           (vrf_tgt),
    .operand_o       (vrf_operand),
    .operand_valid_o (vrf_operand_valid)
  );

  ////////////////////////////////////////////////
  // Operand queues
  ////////////////////////////////////////////////

  operand_queue #(.Depth(OpQueueDepth)) u_opq_a (
    .clk_i, .rst_ni,
    .push_valid_i (vrf_operand_valid[OPQ_A]),
    .push_data_i  (vrf_operand[OPQ_A]),
    .space_ok_o   (opq_space_ok[OPQ_A]),
    .pop_data_o   (opa_data),
    .pop_valid_o  (opa_valid),
    .pop_ready_i  (opa_ready)
  );

  operand_queue #(.Depth(OpQueueDepth)) u_opq_b (
    .clk_i, .rst_ni,
    .push_valid_i (vrf_operand_valid[OPQ_B]),
    .push_data_i  (vrf_operand[OPQ_B]),
    .space_ok_o   (opq_space_ok[OPQ_B]),
    .pop_data_o   (opb_data),
    .pop_valid_o  (opb_valid),
    .pop_ready_i  (opb_ready)
  );

  lane_exec_unit u_exec (
    .clk_i, .rst_ni,
    .exec_start_i (exec_start),
    .exec_op_i    (exec_op),
    .exec_vd_i    (exec_vd),
    .exec_vl_i    (exec_vl),
    .exec_done_o  (exec_done),
    .opa_data_i   (opa_data),
    .opa_valid_i  (opa_valid),
    .opa_ready_o  (opa_ready),
    .opb_data_i   (opb_data),
    .opb_valid_i  (opb_valid),
    .opb_ready_o  (opb_ready),
    .res_req_o    (res_req),
    .res_vreg_o   (res_vreg),
    .res_elem_o   (res_elem),
    .res_wdata_o  (res_wdata),
    .res_gnt_i    (res_gnt),
    .stu_operand_o, .stu_operand_valid_o, .stu_operand_ready_i
  );

endmodule

/* rtl/lane_exec_unit.sv */
// Lane execution unit
// Elementwise integer ALU with result write-back, and store forwarding

module lane_exec_unit
  import lane_pkg::*;
  import vinsn_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // Operation from the sequencer
  input  logic      exec_start_i,
  input  vop_e      exec_op_i,
  input  vreg_t     exec_vd_i,
  input  vl_t       exec_vl_i,
  output logic      exec_done_o,
  // Operand queues
  input  elen_t     opa_data_i,
  input  logic      opa_valid_i,
  output logic      opa_ready_o,
  input  elen_t     opb_data_i,
  input  logic      opb_valid_i,
  output logic      opb_ready_o,
  // Result write-back
  output logic      res_req_o,
  output vreg_t     res_vreg_o,
  output elem_idx_t res_elem_o,
  output elen_t     res_wdata_o,
  input  logic      res_gnt_i,
  // Store port
  output elen_t     stu_operand_o,
  output logic      stu_operand_valid_o,
  input  logic      stu_operand_ready_i
);

  logic      active_q, done_q, res_valid_q;
  vl_t       cnt_q;
  vop_e      op_q;
  vreg_t     vd_q;
  vl_t       vl_q;
  elem_idx_t res_elem_q;
  elen_t     res_data_q;
  elen_t     alu_res;
  logic      is_store, more, can_load;
  logic      alu_pop, st_fire, res_fire, last_res, last_st;

  assign is_store = (op_q == VSTORE);
  assign more     = (cnt_q < vl_q);
  // The result register frees up in the cycle its write is granted
  assign can_load = !res_valid_q || res_gnt_i;
  assign alu_pop  = active_q && !is_store && more && can_load && opa_valid_i && opb_valid_i;
  assign st_fire  = stu_operand_valid_o && stu_operand_ready_i;
  assign res_fire = res_valid_q && res_gnt_i;
  assign last_res = res_fire && ({1'b0, res_elem_q} == vl_q - vl_t'(1));
  assign last_st  = st_fire && (cnt_q == vl_q - vl_t'(1));

  assign opa_ready_o = alu_pop;
  assign opb_ready_o = alu_pop || st_fire;

  assign stu_operand_o       = opb_data_i;
  assign stu_operand_valid_o = active_q && is_store && more && opb_valid_i;

  assign res_req_o   = res_valid_q;
  assign res_vreg_o  = vd_q;
  assign res_elem_o  = res_elem_q;
  assign res_wdata_o = res_data_q;
  assign exec_done_o = done_q;

  // Queue A holds vs1, queue B holds vs2, so VSUB gives vs2 - vs1
  always_comb begin
    case (op_q)
      VADD:    alu_res = opb_data_i + opa_data_i;
      VSUB:    alu_res = opb_data_i - opa_data_i;
      VAND:    alu_res = opb_data_i & opa_data_i;
      VOR:     alu_res = opb_data_i | opa_data_i;
      VXOR:    alu_res = opb_data_i ^ opa_data_i;
      default: alu_res = '0;
    endcase
  end

  ////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      done_q      <= 1'b0;
      res_valid_q <= 1'b0;
      cnt_q       <= '0;
    end else begin
      done_q <= 1'b0;
      if (exec_start_i) begin
        cnt_q    <= '0;
        active_q <= (exec_vl_i != '0);
        done_q   <= (exec_vl_i == '0);
      end else if (active_q) begin
        if (alu_pop || st_fire) begin
          cnt_q <= cnt_q + vl_t'(1);
        end
        if (alu_pop) begin
          res_valid_q <= 1'b1;
        end else if (res_fire) begin
          res_valid_q <= 1'b0;
        end
        if (last_res || last_st) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (exec_start_i) begin
      op_q <= exec_op_i;
      vd_q <= exec_vd_i;
      vl_q <= exec_vl_i;
    end
    if (alu_pop) begin
      res_elem_q <= elem_idx_t'(cnt_q);
      res_data_q <= alu_res;
    end
  end

endmodule

/* rtl/lane_pkg.sv */
// Lane geometry package
// Register-file banking, element widths and the operand queue selector

package lane_pkg;

  ////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////

  localparam int unsigned ElenW        = 32;
  localparam int unsigned NrVRegs      = 32;
  localparam int unsigned ElemsPerVreg = 8;
  localparam int unsigned NrBanks      = 2;
  localparam int unsigned NrOpQueues   = 2;
  localparam int unsigned OpQueueDepth = 4;

  // Each bank holds half of all elements
  localparam int unsigned BankWords = NrVRegs * ElemsPerVreg / NrBanks;

  ////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////

  typedef logic [ElenW-1:0]                  elen_t;
  typedef logic [ElenW/8-1:0]                strb_t;
  typedef logic [$clog2(NrVRegs)-1:0]        vreg_t;
  typedef logic [$clog2(ElemsPerVreg)-1:0]   elem_idx_t;
  // Vector length runs from 0 up to ElemsPerVreg
  typedef logic [$clog2(ElemsPerVreg+1)-1:0] vl_t;
  typedef logic [$clog2(BankWords)-1:0]      bank_addr_t;

  // Destination of a register-file read
  typedef enum logic {
    OPQ_A = 1'b0,
    OPQ_B = 1'b1
  } opq_sel_e;

endpackage

/* rtl/lane_sequencer.sv */
// Lane sequencer
// Accepts one instruction, walks its elements issuing operand reads
// and reports completion when the execution unit finishes

module lane_sequencer
  import lane_pkg::*;
  import vinsn_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // Instruction handshake
  input  logic      vinsn_valid_i,
  input  vop_e      vinsn_op_i,
  input  vreg_t     vinsn_vd_i,
  input  vreg_t     vinsn_vs1_i,
  input  vreg_t     vinsn_vs2_i,
  input  vl_t       vinsn_vl_i,
  input  vid_t      vinsn_id_i,
  output logic      vinsn_ready_o,
  output logic      vinsn_done_o,
  output vid_t      vinsn_done_id_o,
  // Operand read requests
  output logic      rd_req_valid_o,
  output vreg_t     rd_req_vreg_o,
  output elem_idx_t rd_req_elem_o,
  output opq_sel_e  rd_req_opq_o,
  input  logic      rd_req_ready_i,
  // Execution unit
  output logic      exec_start_o,
  output vop_e      exec_op_o,
  output vreg_t     exec_vd_o,
  output vl_t       exec_vl_o,
  input  logic      exec_done_i
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_DONE
  } state_e;

  state_e    state_q;
  elem_idx_t elem_q;
  logic      phase_b_q;
  logic      start_q;
  vop_e      op_q;
  vreg_t     vd_q, vs1_q, vs2_q;
  vl_t       vl_q;
  vid_t      id_q;
  logic      accept, rd_fire, last_elem;

  assign vinsn_ready_o = (state_q == IDLE);
  assign accept        = vinsn_valid_i && vinsn_ready_o;
  assign rd_fire       = rd_req_valid_o && rd_req_ready_i;
  assign last_elem     = ({1'b0, elem_q} == vl_q - vl_t'(1));

  // ALU ops read vs1 into A then vs2 into B, stores read only vs2
  assign rd_req_valid_o = (state_q == ISSUE);
  assign rd_req_vreg_o  = phase_b_q ? vs2_q : vs1_q;
  assign rd_req_elem_o  = elem_q;
  assign rd_req_opq_o   = phase_b_q ? OPQ_B : OPQ_A;

  assign exec_start_o = start_q;
  assign exec_op_o    = op_q;
  assign exec_vd_o    = vd_q;
  assign exec_vl_o    = vl_q;

  assign vinsn_done_o    = (state_q == WAIT_DONE) && exec_done_i;
  assign vinsn_done_id_o = id_q;

  ////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      elem_q    <= '0;
      phase_b_q <= 1'b0;
      start_q   <= 1'b0;
    end else begin
      start_q <= accept;
      case (state_q)
        IDLE: begin
          if (accept) begin
            elem_q    <= '0;
            phase_b_q <= (vinsn_op_i == VSTORE);
            // Zero length goes straight to the done handshake
            state_q   <= (vinsn_vl_i == '0) ? WAIT_DONE : ISSUE;
          end
        end
        ISSUE: begin
          if (rd_fire) begin
            if (!phase_b_q) begin
              phase_b_q <= 1'b1;
            end else begin
              phase_b_q <= (op_q == VSTORE);
              if (last_elem) begin
                state_q <= WAIT_DONE;
              end else begin
                elem_q <= elem_q + elem_idx_t'(1);
              end
            end
          end
        end
        WAIT_DONE: begin
          if (exec_done_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Instruction fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= vinsn_op_i;
      vd_q  <= vinsn_vd_i;
      vs1_q <= vinsn_vs1_i;
      vs2_q <= vinsn_vs2_i;
      vl_q  <= vinsn_vl_i;
      id_q  <= vinsn_id_i;
    end
  end

endmodule

/* rtl/operand_queue.sv */
// Operand queue
// FIFO between the register file and the execution unit

module operand_queue
  import lane_pkg::*;
#(
  parameter int unsigned Depth = OpQueueDepth
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_valid_i,
  input  elen_t push_data_i,
  output logic  space_ok_o,
  output elen_t pop_data_o,
  output logic  pop_valid_o,
  input  logic  pop_ready_i
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(Depth - 1)) ? '0 : p + ptr_t'(1);
  endfunction

  elen_t mem_q [Depth];
  ptr_t  wr_ptr_q, rd_ptr_q;
  cnt_t  cnt_q;
  logic  push, pop;

  assign push        = push_valid_i && (cnt_q != cnt_t'(Depth));
  assign pop         = pop_valid_o && pop_ready_i;
  assign pop_valid_o = (cnt_q != '0);
  assign pop_data_o  = mem_q[rd_ptr_q];
  // Two free slots leave room for a read still in the register file
  assign space_ok_o  = (int'(cnt_q) + 2 <= int'(Depth));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (pop && !push) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* rtl/operand_requester.sv */
// Operand requester
// Maps load writes, result writes and operand reads onto the register
// file banks with a fixed priority per bank

module operand_requester
  import lane_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Read requests from the sequencer
  input  logic                        rd_req_valid_i,
  input  vreg_t                       rd_req_vreg_i,
  input  elem_idx_t                   rd_req_elem_i,
  input  opq_sel_e                    rd_req_opq_i,
  output logic                        rd_req_ready_o,
  input  logic       [NrOpQueues-1:0] opq_space_ok_i,
  // Result writes
  input  logic                        res_req_i,
  input  vreg_t                       res_vreg_i,
  input  elem_idx_t                   res_elem_i,
  input  elen_t                       res_wdata_i,
  output logic                        res_gnt_o,
  // Load writes
  input  logic                        ldu_req_i,
  input  vreg_t                       ldu_vreg_i,
  input  elem_idx_t                   ldu_elem_i,
  input  elen_t                       ldu_wdata_i,
  input  strb_t                       ldu_be_i,
  output logic                        ldu_gnt_o,
  // Register file banks
  output logic       [NrBanks-1:0]    vrf_req_o,
  output logic       [NrBanks-1:0]    vrf_wen_o,
  output bank_addr_t [NrBanks-1:0]    vrf_addr_o,
  output elen_t      [NrBanks-1:0]    vrf_wdata_o,
  output strb_t      [NrBanks-1:0]    vrf_be_o,
  output opq_sel_e   [NrBanks-1:0]    vrf_tgt_o
);

  // Consecutive elements of a register alternate between the banks
  function automatic logic bank_of(vreg_t vreg, elem_idx_t elem);
    return vreg[0] ^ elem[0];
  endfunction

  // The bank select is implied by the low element bit
  function automatic bank_addr_t addr_of(vreg_t vreg, elem_idx_t elem);
    return {vreg, elem[2:1]};
  endfunction

  logic                  ld_bank, res_bank, rd_bank;
  logic                  rd_fire;
  logic [NrOpQueues-1:0] inflight_q;

  assign ld_bank  = bank_of(ldu_vreg_i, ldu_elem_i);
  assign res_bank = bank_of(res_vreg_i, res_elem_i);
  assign rd_bank  = bank_of(rd_req_vreg_i, rd_req_elem_i);

  // Loads always win their bank
  assign ldu_gnt_o = ldu_req_i;
  assign res_gnt_o = res_req_i && !(ldu_req_i && ld_bank == res_bank);

  // At most one read in flight per queue
  assign rd_req_ready_o = opq_space_ok_i[rd_req_opq_i] && !inflight_q[rd_req_opq_i] &&
                          !(ldu_req_i && ld_bank == rd_bank) &&
                          !(res_req_i && res_bank == rd_bank);
  assign rd_fire = rd_req_valid_i && rd_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
    end else begin
      for (int q = 0; q < NrOpQueues; q++) begin
        inflight_q[q] <= rd_fire && (rd_req_opq_i == opq_sel_e'(q));
      end
    end
  end

  ////////////////////////////////////////////////
  // Bank arbitration
  ////////////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < NrBanks; b++) begin
      vrf_req_o[b]   = 1'b0;
      vrf_wen_o[b]   = 1'b0;
      vrf_addr_o[b]  = addr_of(rd_req_vreg_i, rd_req_elem_i);
      vrf_wdata_o[b] = '0;
      vrf_be_o[b]    = '0;
      vrf_tgt_o[b]   = rd_req_opq_i;
      if (ldu_req_i && ld_bank == 1'(b)) begin
        vrf_req_o[b]   = 1'b1;
        vrf_wen_o[b]   = 1'b1;
        vrf_addr_o[b]  = addr_of(ldu_vreg_i, ldu_elem_i);
        vrf_wdata_o[b] = ldu_wdata_i;
        vrf_be_o[b]    = ldu_be_i;
      end else if (res_req_i && res_bank == 1'(b)) begin
        // Results always write the full element
        vrf_req_o[b]   = 1'b1;
        vrf_wen_o[b]   = 1'b1;
        vrf_addr_o[b]  = addr_of(res_vreg_i, res_elem_i);
        vrf_wdata_o[b] = res_wdata_i;
        vrf_be_o[b]    = '1;
      end else if (rd_fire && rd_bank == 1'(b)) begin
        vrf_req_o[b] = 1'b1;
      end
    end
  end

endmodule

/* rtl/vector_regfile.sv */
// Vector register file slice
// Single-port banks with byte-enable writes and tagged one-cycle reads

module vector_regfile
  import lane_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic       [NrBanks-1:0]    req_i,
  input  logic       [NrBanks-1:0]    wen_i,
  input  bank_addr_t [NrBanks-1:0]    addr_i,
  input  elen_t      [NrBanks-1:0]    wdata_i,
  input  strb_t      [NrBanks-1:0]    be_i,
  input  opq_sel_e   [NrBanks-1:0]    tgt_i,
  output elen_t      [NrOpQueues-1:0] operand_o,
  output logic       [NrOpQueues-1:0] operand_valid_o
);

  elen_t                  mem_q [NrBanks][BankWords];
  elen_t    [NrBanks-1:0] rdata_q;
  opq_sel_e [NrBanks-1:0] rtgt_q;
  logic     [NrBanks-1:0] rvalid_q;

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < NrBanks; b++) begin
      if (req_i[b] && wen_i[b]) begin
        for (int i = 0; i < ElenW / 8; i++) begin
          if (be_i[b][i]) begin
            mem_q[b][addr_i[b]][8*i +: 8] <= wdata_i[b][8*i +: 8];
          end
        end
      end else if (req_i[b]) begin
        rdata_q[b] <= mem_q[b][addr_i[b]];
      end
      rtgt_q[b] <= tgt_i[b];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= '0;
    end else begin
      rvalid_q <= req_i & ~wen_i;
    end
  end

  // Steer each returning word to the queue named by its tag
  always_comb begin
    operand_o       = '0;
    operand_valid_o = '0;
    for (int b = 0; b < NrBanks; b++) begin
      if (rvalid_q[b]) begin
        operand_o[rtgt_q[b]]       = rdata_q[b];
        operand_valid_o[rtgt_q[b]] = 1'b1;
      end
    end
  end

endmodule

/* rtl/vinsn_pkg.sv */
// Vector instruction package
// Opcode encoding and instruction ID

package vinsn_pkg;

  ////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////

  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSUB   = 3'd1,
    VAND   = 3'd2,
    VOR    = 3'd3,
    VXOR   = 3'd4,
    VSTORE = 3'd5
  } vop_e;

  // Tag echoed back with the done pulse
  typedef logic [1:0] vid_t;

endpackage
